//--- hdl/snake_pkg.sv
package snake_pkg;

    //////////////////////////////////////////////////////////////////////
    // grid and game widths
    //////////////////////////////////////////////////////////////////////

    // one grid coordinate, 32 cells per axis
    typedef logic [4:0] coord_t;

    // level 0 to 3
    typedef logic [1:0] level_t;

    // bites eaten on the current level
    typedef logic [2:0] bite_cnt_t;

    // obstacle index, highest used is 29
    typedef logic [4:0] obs_idx_t;

    // one cell on the grid
    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_t;

    // everything the checkers need for one move
    typedef struct packed {
        cell_t head;
        cell_t seg3;
        cell_t seg4;
        cell_t food;
    } step_req_t;

    // status word as read back over APB
    typedef struct packed {
        logic      busy;
        logic      die;
        logic      grow;
        logic      rst_size;
        level_t    level;
        bite_cnt_t bites;
        logic      spare;
    } game_status_t;

    // level keeper states
    typedef enum logic [1:0] {
        idle,
        wait_scan,
        commit
    } keeper_state_e;

    //////////////////////////////////////////////////////////////////////
    // APB register map, byte offsets
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0] REG_HEAD   = 8'h00;
    localparam logic [7:0] REG_BODY   = 8'h04;
    localparam logic [7:0] REG_FOOD   = 8'h08;
    localparam logic [7:0] REG_CTRL   = 8'h0C;
    localparam logic [7:0] REG_STATUS = 8'h10;

    // obstacles added with every level
    localparam int OBS_PER_LEVEL = 10;

endpackage

//--- hdl/snake_apb_regs.sv
`timescale 1ns/1ps

module snake_apb_regs
    import snake_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [7:0]   paddr,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr,
    input  game_status_t status,
    output step_req_t    step_req,
    output logic         step_go,
    output logic         restart
);

    // bus layout of one cell: x in 4:0, y in 12:8
    function automatic cell_t unpack_cell(input logic [15:0] half);
        cell_t c;
        c.x = half[4:0];
        c.y = half[12:8];
        return c;
    endfunction

    function automatic logic [15:0] pack_cell(input cell_t c);
        return {3'b000, c.y, 3'b000, c.x};
    endfunction

    logic sel_head;
    logic sel_body;
    logic sel_food;
    logic sel_ctrl;
    logic sel_status;
    logic addr_hit;
    logic access;
    logic step_busy;
    logic wr_ok;

    //////////////////////////////////////////////////////////////////////
    // address decode and error response
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_head   = paddr == REG_HEAD;
        sel_body   = paddr == REG_BODY;
        sel_food   = paddr == REG_FOOD;
        sel_ctrl   = paddr == REG_CTRL;
        sel_status = paddr == REG_STATUS;
        addr_hit   = sel_head | sel_body | sel_food | sel_ctrl | sel_status;
        // access phase only, no wait states
        access     = psel & penable;
        // a step while the keeper is still working is refused
        step_busy  = pwrite & sel_ctrl & pwdata[0] & status.busy;
        pslverr    = access & (~addr_hit | step_busy);
        // refused accesses leave every register alone
        wr_ok      = access & pwrite & ~pslverr;
    end

    assign pready = 1'b1;

    // read mux, coordinates read back in their write layout
    always_comb begin
        prdata = '0;
        if (sel_head) begin
            prdata[15:0] = pack_cell(step_req.head);
        end else if (sel_body) begin
            prdata = {pack_cell(step_req.seg4), pack_cell(step_req.seg3)};
        end else if (sel_food) begin
            prdata[15:0] = pack_cell(step_req.food);
        end else if (sel_status) begin
            prdata[$bits(game_status_t)-1:0] = status;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // coordinate registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_ok && sel_head) begin
            step_req.head <= unpack_cell(pwdata[15:0]);
        end
        // seg3 low half, seg4 high half
        if (wr_ok && sel_body) begin
            step_req.seg3 <= unpack_cell(pwdata[15:0]);
            step_req.seg4 <= unpack_cell(pwdata[31:16]);
        end
        if (wr_ok && sel_food) begin
            step_req.food <= unpack_cell(pwdata[15:0]);
        end
    end

    // control writes become one-cycle pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            step_go <= 1'b0;
            restart <= 1'b0;
        end else begin
            step_go <= wr_ok & sel_ctrl & pwdata[0];
            restart <= wr_ok & sel_ctrl & pwdata[1];
        end
    end

    // the keeper must be idle whenever a step is launched
    a_step_not_busy: assert property (@(posedge clk) disable iff (rst)
        step_go |-> !status.busy)
        else $error("step_go issued while keeper busy");

endmodule

//--- hdl/food_tracker.sv
`timescale 1ns/1ps

module food_tracker
    import snake_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      step_go,
    input  step_req_t step_req,
    output logic      eaten
);

    logic on_food;

    //////////////////////////////////////////////////////////////////////
    // head against food
    //////////////////////////////////////////////////////////////////////

    // both axes must agree
    always_comb begin
        on_food = (step_req.head.x == step_req.food.x) &&
                  (step_req.head.y == step_req.food.y);
    end

    // sampled once per step, held for the keeper's commit
    always_ff @(posedge clk) begin
        if (rst) begin
            eaten <= 1'b0;
        end else if (step_go) begin
            eaten <= on_food;
        end
    end

    // result stays put between steps even if the host rewrites registers
    a_eaten_held: assert property (@(posedge clk) disable iff (rst)
        !$past(step_go) && !$past(rst) |-> $stable(eaten))
        else $error("eaten changed outside a step");

endmodule

//--- hdl/collision_scan.sv
`timescale 1ns/1ps

module collision_scan
    import snake_pkg::*;
#(
    parameter int GRID_MAX = 31
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      step_go,
    input  step_req_t step_req,
    input  level_t    level,
    output logic      hit,
    output logic      scan_done
);

    // obstacle k at x = 10k+10, y = 5k+10, both mod 32
    localparam coord_t OBS_X_BASE = 5'd10;
    localparam coord_t OBS_Y_BASE = 5'd10;
    localparam coord_t OBS_X_STEP = 5'd10;
    localparam coord_t OBS_Y_STEP = 5'd5;

    logic     active;
    cell_t    head_q;
    coord_t   acc_x;
    coord_t   acc_y;
    obs_idx_t obs_idx;
    obs_idx_t obs_count;
    logic     fence_hit;
    logic     body_hit;
    logic     obs_hit;
    logic     obs_end;

    //////////////////////////////////////////////////////////////////////
    // per-cycle checks
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // obstacles present on this level
        case (level)
            2'd0:    obs_count = '0;
            2'd1:    obs_count = obs_idx_t'(OBS_PER_LEVEL);
            2'd2:    obs_count = obs_idx_t'(2 * OBS_PER_LEVEL);
            default: obs_count = obs_idx_t'(3 * OBS_PER_LEVEL);
        endcase
        // first cycle, fence on all four sides
        fence_hit = (step_req.head.x == '0) || (step_req.head.x == coord_t'(GRID_MAX)) ||
                    (step_req.head.y == '0) || (step_req.head.y == coord_t'(GRID_MAX));
        // first cycle, the two trailing segments
        body_hit  = fence_hit || (step_req.head == step_req.seg3) ||
                    (step_req.head == step_req.seg4);
        // later cycles, one obstacle each
        obs_hit   = active && (head_q.x == acc_x) && (head_q.y == acc_y);
        obs_end   = obs_idx == obs_count - 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // scan control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            hit       <= 1'b0;
            scan_done <= 1'b0;
            obs_idx   <= '0;
        end else begin
            scan_done <= 1'b0;
            if (step_go) begin
                obs_idx <= '0;
                // done at once on a body or fence hit, or with no obstacles
                if (body_hit || obs_count == '0) begin
                    active    <= 1'b0;
                    hit       <= body_hit;
                    scan_done <= 1'b1;
                end else begin
                    active <= 1'b1;
                    hit    <= 1'b0;
                end
            end else if (active) begin
                // stop early on the first obstacle hit
                if (obs_hit || obs_end) begin
                    active    <= 1'b0;
                    hit       <= obs_hit;
                    scan_done <= 1'b1;
                end else begin
                    obs_idx <= obs_idx + 1'b1;
                end
            end
        end
    end

    // head copy and obstacle accumulators, wrap mod 32 by width
    always_ff @(posedge clk) begin
        if (step_go) begin
            head_q <= step_req.head;
            acc_x  <= OBS_X_BASE;
            acc_y  <= OBS_Y_BASE;
        end else if (active) begin
            acc_x <= acc_x + OBS_X_STEP;
            acc_y <= acc_y + OBS_Y_STEP;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        scan_done |=> !scan_done)
        else $error("scan_done longer than one cycle");

    // level 3 has obstacles 0 to 29 only
    a_idx_range: assert property (@(posedge clk) disable iff (rst)
        obs_idx < obs_idx_t'(3 * OBS_PER_LEVEL))
        else $error("obstacle index out of range");

endmodule

//--- hdl/level_keeper.sv
`timescale 1ns/1ps

module level_keeper
    import snake_pkg::*;
#(
    parameter int BITES_PER_LEVEL = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         step_go,
    input  logic         restart,
    input  logic         eaten,
    input  logic         hit,
    input  logic         scan_done,
    output level_t       level,
    output game_status_t status
);

    keeper_state_e state;
    bite_cnt_t     bites;
    logic          die;
    logic          grow;
    logic          rst_size;
    logic          last_bite;

    // this bite completes the level
    assign last_bite = bites == bite_cnt_t'(BITES_PER_LEVEL - 1);

    //////////////////////////////////////////////////////////////////////
    // step sequencing and level bookkeeping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            level    <= '0;
            bites    <= '0;
            die      <= 1'b0;
            grow     <= 1'b0;
            rst_size <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (restart) begin
                        level <= '0;
                        bites <= '0;
                    end
                    // flags describe the last step only
                    if (restart || step_go) begin
                        die      <= 1'b0;
                        grow     <= 1'b0;
                        rst_size <= 1'b0;
                    end
                    if (step_go) begin
                        state <= wait_scan;
                    end
                end
                wait_scan: begin
                    if (scan_done) begin
                        state <= commit;
                    end
                end
                commit: begin
                    state <= idle;
                    if (hit) begin
                        // death restarts the game at level 0
                        die   <= 1'b1;
                        level <= '0;
                        bites <= '0;
                    end else if (eaten) begin
                        grow <= 1'b1;
                        if (last_bite) begin
                            bites    <= '0;
                            rst_size <= 1'b1;
                            // level 3 is the top, stays there
                            if (level != 2'd3) begin
                                level <= level + 1'b1;
                            end
                        end else begin
                            bites <= bites + 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // status word for the register block
    always_comb begin
        status          = '0;
        status.busy     = state != idle;
        status.die      = die;
        status.grow     = grow;
        status.rst_size = rst_size;
        status.level    = level;
        status.bites    = bites;
    end

    // the scanner only reports for a step this keeper launched
    a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
        scan_done |-> state == wait_scan)
        else $error("scan_done outside wait_scan");

endmodule

//--- hdl/snake_game_top.sv
`timescale 1ns/1ps

module snake_game_top
    import snake_pkg::*;
#(
    parameter int GRID_MAX        = 31,
    parameter int BITES_PER_LEVEL = 5
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    //////////////////////////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////////////////////////

    step_req_t    step_req;
    game_status_t status;
    level_t       level;
    logic         step_go;
    logic         restart;
    logic         eaten;
    logic         hit;
    logic         scan_done;

    // host side, registers and command pulses
    snake_apb_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .status   (status),
        .step_req (step_req),
        .step_go  (step_go),
        .restart  (restart)
    );

    // food and collision judged side by side
    food_tracker u_food (
        .clk      (clk),
        .rst      (rst),
        .step_go  (step_go),
        .step_req (step_req),
        .eaten    (eaten)
    );

    collision_scan #(
        .GRID_MAX (GRID_MAX)
    ) u_scan (
        .clk       (clk),
        .rst       (rst),
        .step_go   (step_go),
        .step_req  (step_req),
        .level     (level),
        .hit       (hit),
        .scan_done (scan_done)
    );

    // combines both results once the scan ends
    level_keeper #(
        .BITES_PER_LEVEL (BITES_PER_LEVEL)
    ) u_keeper (
        .clk       (clk),
        .rst       (rst),
        .step_go   (step_go),
        .restart   (restart),
        .eaten     (eaten),
        .hit       (hit),
        .scan_done (scan_done),
        .level     (level),
        .status    (status)
    );

endmodule

//--- test/snake_game_tb.sv
`timescale 1ns/1ps

module snake_game_tb
    import snake_pkg::*;
();

    // one table row: step inputs and the status expected after commit
    typedef struct packed {
        cell_t     head;
        cell_t     seg3;
        cell_t     seg4;
        cell_t     food;
        logic      die;
        logic      grow;
        logic      rst_size;
        level_t    level;
        bite_cnt_t bites;
    } row_t;

    localparam int N_RANDOM = 8;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    row_t rows[$];
    int   errors;
    int   test_errs;
    int   n_tests;
    int   cycles;
    int   limit;

    snake_game_top #(
        .GRID_MAX        (31),
        .BITES_PER_LEVEL (5)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit, set once the table length is known
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic cell_t make_cell(input int x, input int y);
        cell_t c;
        c.x = coord_t'(x);
        c.y = coord_t'(y);
        return c;
    endfunction

    // bus layout: x in 4:0, y in 12:8
    function automatic logic [15:0] bus_cell(input cell_t c);
        return {3'b000, c.y, 3'b000, c.x};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // fence, both segments and obstacles 0 to 10*level-1
    function automatic logic collides(input cell_t h, input cell_t s3, input cell_t s4,
                                      input int lvl);
        int   k;
        logic c;
        c = (h.x == 5'd0) || (h.x == 5'd31) || (h.y == 5'd0) || (h.y == 5'd31);
        c = c || (h == s3) || (h == s4);
        for (k = 0; k < lvl * 10; k++) begin
            if (h.x == coord_t'((10 * k + 10) % 32) && h.y == coord_t'((5 * k + 10) % 32)) begin
                c = 1'b1;
            end
        end
        return c;
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %s", n_tests, name, (test_errs == 0) ? "ok" : "FAILED");
        n_tests++;
        test_errs = 0;
    endtask

    task automatic add_row(input cell_t h, input cell_t f, input int d, input int g,
                           input int rs, input int lvl, input int b);
        row_t r;
        r.head     = h;
        r.seg3     = make_cell(21, 21);
        r.seg4     = make_cell(21, 22);
        r.food     = f;
        r.die      = d != 0;
        r.grow     = g != 0;
        r.rst_size = rs != 0;
        r.level    = level_t'(lvl);
        r.bites    = bite_cnt_t'(b);
        rows.push_back(r);
    endtask

    // n bites in a row, odd x keeps clear of every obstacle
    task automatic add_bites(input int n, input int lvl);
        int i;
        int b;
        int rs;
        b = 0;
        for (i = 0; i < n; i++) begin
            b++;
            rs = 0;
            if (b == 5) begin
                b  = 0;
                rs = 1;
                if (lvl < 3) begin
                    lvl++;
                end
            end
            add_row(make_cell(5, 2 + i % 28), make_cell(5, 2 + i % 28), 0, 1, rs, lvl, b);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // APB access, driven on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err, input string what);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #2;
        check_val({what, " pready"}, int'(pready), 1);
        check_val({what, " pslverr"}, int'(pslverr), int'(exp_err));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err, input string what);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #2;
        data = prdata;
        check_val({what, " pready"}, int'(pready), 1);
        check_val({what, " pslverr"}, int'(pslverr), int'(exp_err));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // step sequence
    //////////////////////////////////////////////////////////////////////

    task automatic load_cells(input row_t r);
        apb_write(REG_HEAD, {16'h0, bus_cell(r.head)}, 1'b0, "head write");
        apb_write(REG_BODY, {bus_cell(r.seg4), bus_cell(r.seg3)}, 1'b0, "body write");
        apb_write(REG_FOOD, {16'h0, bus_cell(r.food)}, 1'b0, "food write");
    endtask

    // first poll must see busy, then poll until it clears
    task automatic wait_idle(output game_status_t st);
        logic [31:0] d;
        apb_read(REG_STATUS, d, 1'b0, "status poll");
        st = d[$bits(game_status_t)-1:0];
        check_val("busy after step", int'(st.busy), 1);
        while (st.busy) begin
            apb_read(REG_STATUS, d, 1'b0, "status poll");
            st = d[$bits(game_status_t)-1:0];
        end
    endtask

    task automatic check_status(input game_status_t st, input row_t exp);
        check_val("busy", int'(st.busy), 0);
        check_val("die", int'(st.die), int'(exp.die));
        check_val("grow", int'(st.grow), int'(exp.grow));
        check_val("rst_size", int'(st.rst_size), int'(exp.rst_size));
        check_val("level", int'(st.level), int'(exp.level));
        check_val("bites", int'(st.bites), int'(exp.bites));
    endtask

    task automatic run_step(input row_t r);
        game_status_t st;
        load_cells(r);
        apb_write(REG_CTRL, 32'h1, 1'b0, "step write");
        wait_idle(st);
        check_status(st, r);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]  d;
        logic [31:0]  seed;
        game_status_t st;
        row_t         r;
        int           i;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rst       = 1'b1;
        errors    = 0;
        test_errs = 0;
        n_tests   = 0;
        cycles    = 0;
        seed      = 32'h1d4f;

        // bite at level 0, a step beside the food, then the left fence
        add_row(make_cell(3, 5), make_cell(3, 5), 0, 1, 0, 0, 1);
        add_row(make_cell(3, 6), make_cell(9, 9), 0, 0, 0, 0, 1);
        add_row(make_cell(0, 12), make_cell(9, 9), 1, 0, 0, 0, 0);
        add_bites(5, 0);
        // obstacle 0 exists at level 1, obstacle 10 does not
        add_row(make_cell(14, 28), make_cell(9, 9), 0, 0, 0, 1, 0);
        add_row(make_cell(10, 10), make_cell(9, 9), 1, 0, 0, 0, 0);
        add_row(make_cell(10, 10), make_cell(9, 9), 0, 0, 0, 0, 0);
        add_row(make_cell(14, 28), make_cell(9, 9), 0, 0, 0, 0, 0);
        // body hits after a bite, and the top fence
        add_row(make_cell(3, 20), make_cell(3, 20), 0, 1, 0, 0, 1);
        add_row(make_cell(21, 21), make_cell(9, 9), 1, 0, 0, 0, 0);
        add_row(make_cell(3, 21), make_cell(3, 21), 0, 1, 0, 0, 1);
        add_row(make_cell(21, 22), make_cell(9, 9), 1, 0, 0, 0, 0);
        add_row(make_cell(3, 31), make_cell(9, 9), 1, 0, 0, 0, 0);
        // climb to level 3 and stay there
        add_bites(20, 0);
        limit = (rows.size() + N_RANDOM + 6) * 40 + 500;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apb_read(REG_STATUS, d, 1'b0, "reset status");
        check_val("reset status word", int'(d), 0);
        finish_test("reset");

        for (i = 0; i < rows.size(); i++) begin
            run_step(rows[i]);
            finish_test($sformatf("row %0d", i));
        end

        // second step is refused while level 3 is still scanning
        r = rows[rows.size() - 1];
        r.head     = make_cell(3, 9);
        r.food     = make_cell(3, 9);
        r.grow     = 1'b1;
        r.rst_size = 1'b0;
        r.bites    = 3'd1;
        load_cells(r);
        apb_write(REG_CTRL, 32'h1, 1'b0, "step write");
        apb_write(REG_CTRL, 32'h1, 1'b1, "step while busy");
        wait_idle(st);
        check_status(st, r);
        repeat (5) @(negedge clk);
        apb_read(REG_STATUS, d, 1'b0, "status reread");
        check_status(d[$bits(game_status_t)-1:0], r);
        finish_test("step while busy");

        apb_write(8'h14, 32'h1, 1'b1, "unmapped write");
        apb_read(8'h14, d, 1'b1, "unmapped read");
        finish_test("unmapped address");

        apb_write(REG_CTRL, 32'h2, 1'b0, "restart write");
        apb_read(REG_STATUS, d, 1'b0, "status after restart");
        check_val("status after restart", int'(d), 0);
        finish_test("restart");

        // random safe interior cells at level 0, never on the food
        for (i = 0; i < N_RANDOM; i++) begin
            r.seg3 = make_cell(21, 21);
            r.seg4 = make_cell(21, 22);
            r.food = make_cell(9, 9);
            do begin
                seed   = lcg_next(seed);
                r.head = make_cell(1 + int'(seed[31:16]) % 30, 1 + int'(seed[23:8]) % 30);
            end while (collides(r.head, r.seg3, r.seg4, 0) || r.head == r.food);
            r.die      = collides(r.head, r.seg3, r.seg4, 0);
            r.grow     = !r.die && (r.head == r.food);
            r.rst_size = 1'b0;
            r.level    = 2'd0;
            r.bites    = bite_cnt_t'(int'(r.grow));
            run_step(r);
            finish_test($sformatf("random %0d", i));
        end

        $display("tests %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/snake_pkg.sv
hdl/snake_apb_regs.sv
hdl/food_tracker.sv
hdl/collision_scan.sv
hdl/level_keeper.sv
hdl/snake_game_top.sv
test/snake_game_tb.sv

//--- run.sh
#!/bin/sh
# build and run the snake game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module snake_game_tb \
    --Mdir obj_dir \
    -f filelist.f

./obj_dir/Vsnake_game_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
